//--- hdl/spi_link_pkg.sv
/*
 * SPI link definitions shared by the master blocks
 * Field widths, controller states and register selects
 */
package spi_link_pkg;

    // Data word width of the FIFOs and the register port
    localparam int WORD_BITS = 32;

    // Address bits sent in every frame header
    localparam int ADDR_BITS = 8;

    // Opcode group width
    localparam int GROUP_BITS = 2;

    // Data length field, up to 255 bits which is 8 words
    localparam int LEN_BITS = 8;

    // Header after the idle bits: address, group, write enable, zero
    localparam int HEADER_BITS = 12;

    // Frame controller states
    typedef enum logic [2:0] {
        idle         = 3'd0,
        setup        = 3'd1,
        send_address = 3'd2,
        send_group   = 3'd3,
        send_we      = 3'd4,
        send_zero    = 3'd5,
        send_data    = 3'd6,
        receive_data = 3'd7
    } frame_state_e;

    // Register port selects
    typedef enum logic [2:0] {
        sel_ctrl      = 3'd0,
        sel_address   = 3'd1,
        sel_length    = 3'd2,
        sel_cmd_data  = 3'd3,
        sel_read_data = 3'd4,
        sel_status    = 3'd5
    } reg_sel_e;

endpackage

//--- hdl/word_fifo.sv
/*
 * Word FIFO with show-ahead output
 * Oldest word is on dout whenever empty is low
 */
`timescale 1ns/1ps

module word_fifo import spi_link_pkg::*; #(
    parameter int DEPTH = 8
) (
    input  logic                 axi_clk,
    input  logic                 reset_b,
    input  logic                 wr_en,
    input  logic [WORD_BITS-1:0] din,
    input  logic                 rd_en,
    output logic [WORD_BITS-1:0] dout,
    output logic                 empty,
    output logic                 full
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    // Storage array
    logic [WORD_BITS-1:0] mem [DEPTH];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                push;
    logic                pop;

    // Pointer advance with wrap, depth need not be a power of two
    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        if (ptr == PTR_BITS'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Qualified strobes keep the pointers sane
    assign push  = wr_en && !full;
    assign pop   = rd_en && !empty;
    assign empty = (count == '0);
    assign full  = (count == CNT_BITS'(DEPTH));
    assign dout  = mem[rd_ptr];

    always_ff @(posedge axi_clk or negedge reset_b) begin
        if (!reset_b) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Occupancy only moves on an unmatched push or pop
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Data array
    always_ff @(posedge axi_clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    a_no_overflow: assert property (@(posedge axi_clk) disable iff (!reset_b)
        wr_en |-> !full);

    a_no_underflow: assert property (@(posedge axi_clk) disable iff (!reset_b)
        rd_en |-> !empty);

endmodule

//--- hdl/spi_ctrl_regs.sv
/*
 * SPI master register block
 * Frame settings, command FIFO feed, read FIFO pops and status
 */
`timescale 1ns/1ps

module spi_ctrl_regs import spi_link_pkg::*; (
    input  logic                  axi_clk,
    input  logic                  reset_b,
    input  logic                  reg_wr_en,
    input  logic                  reg_rd_en,
    input  reg_sel_e              reg_sel,
    input  logic [WORD_BITS-1:0]  reg_wdata,
    input  logic                  done,
    input  logic                  busy,
    input  logic                  cmd_empty,
    input  logic                  read_empty,
    input  logic [WORD_BITS-1:0]  read_dout,
    output logic [WORD_BITS-1:0]  reg_rdata,
    output logic                  cmd_push,
    output logic [WORD_BITS-1:0]  cmd_din,
    output logic                  read_pop,
    output logic                  wnr,
    output logic [ADDR_BITS-1:0]  address,
    output logic [GROUP_BITS-1:0] opcode_group,
    output logic [LEN_BITS-1:0]   data_len
);

    logic                 wr_ctrl;
    logic                 wr_address;
    logic                 wr_len;
    logic [WORD_BITS-1:0] rd_mux;

    // Write decode
    assign wr_ctrl    = reg_wr_en && (reg_sel == sel_ctrl);
    assign wr_address = reg_wr_en && (reg_sel == sel_address);
    assign wr_len     = reg_wr_en && (reg_sel == sel_length);

    // Command words go straight into the command FIFO
    assign cmd_push = reg_wr_en && (reg_sel == sel_cmd_data);
    assign cmd_din  = reg_wdata;

    // Pop only with data present, an empty read returns zero
    assign read_pop = reg_rd_en && (reg_sel == sel_read_data) && !read_empty;

    //////////////////////////////////////////////////////////////////////
    // Frame settings
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge axi_clk or negedge reset_b) begin
        if (!reset_b) begin
            wnr          <= 1'b0;
            opcode_group <= '0;
            address      <= '0;
            data_len     <= '0;
        end else begin
            if (wr_ctrl) begin
                wnr          <= reg_wdata[0];
                opcode_group <= reg_wdata[GROUP_BITS:1];
            end
            if (wr_address) begin
                address <= reg_wdata[ADDR_BITS-1:0];
            end
            // Nonzero length starts a frame, zero aborts one
            if (wr_len) begin
                data_len <= reg_wdata[LEN_BITS-1:0];
            end else if (done) begin
                data_len <= '0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read back
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (reg_sel)
            sel_ctrl:      rd_mux = WORD_BITS'({opcode_group, wnr});
            sel_address:   rd_mux = WORD_BITS'(address);
            sel_length:    rd_mux = WORD_BITS'(data_len);
            sel_read_data: rd_mux = read_empty ? '0 : read_dout;
            // Busy in bit 0, FIFO empties above
            sel_status:    rd_mux = WORD_BITS'({read_empty, cmd_empty, busy});
            default:       rd_mux = '0;
        endcase
    end

    // Data is valid the cycle after the read strobe
    always_ff @(posedge axi_clk) begin
        if (reg_rd_en) begin
            reg_rdata <= rd_mux;
        end
    end

    // Software waits for the frame to end before the next length
    a_len_when_idle: assert property (@(posedge axi_clk) disable iff (!reset_b)
        (wr_len && busy) |-> (reg_wdata[LEN_BITS-1:0] == '0));

endmodule

//--- hdl/spi_frame_controller.sv
/*
 * SPI frame controller
 * Shifts header and write data on pico, packs poci bits into words
 */
`timescale 1ns/1ps

module spi_frame_controller import spi_link_pkg::*; (
    input  logic                  axi_clk,
    input  logic                  reset_b,
    input  logic                  wnr,
    input  logic [ADDR_BITS-1:0]  address,
    input  logic [GROUP_BITS-1:0] opcode_group,
    input  logic [LEN_BITS-1:0]   data_len,
    input  logic                  cmd_empty,
    input  logic [WORD_BITS-1:0]  cmd_dout,
    input  logic                  rd_full,
    input  logic                  poci,
    output logic                  cmd_rd_en,
    output logic                  rd_wr_en,
    output logic [WORD_BITS-1:0]  rd_din,
    output logic                  pico,
    output logic                  cs_b,
    output logic                  spi_clk,
    output logic                  done,
    output logic                  busy
);

    localparam int CNT_BITS  = $clog2(HEADER_BITS);
    localparam int IDX_BITS  = $clog2(WORD_BITS);
    localparam int ADDR_IDX  = $clog2(ADDR_BITS);
    localparam int GROUP_IDX = $clog2(GROUP_BITS);

    frame_state_e state, state_c;

    // Header bit counter, reused by setup, address and group
    logic [CNT_BITS-1:0]  hdr_cnt, hdr_cnt_c;
    // Data bits handled so far in this frame
    logic [LEN_BITS-1:0]  data_cnt, data_cnt_c;
    // Bit position inside the current word
    logic [IDX_BITS-1:0]  bit_idx, bit_idx_c;
    logic [WORD_BITS-1:0] tx_word, tx_word_c;
    logic [WORD_BITS-1:0] rx_word, rx_word_c;

    // No divider, the link runs on the bus clock
    assign spi_clk = axi_clk;

    // A frame is pending from the length write until the length clears
    assign busy = (state != idle) || (data_len != '0);

    always_ff @(posedge axi_clk or negedge reset_b) begin
        if (!reset_b) begin
            state    <= idle;
            hdr_cnt  <= '0;
            data_cnt <= '0;
            bit_idx  <= '0;
        end else begin
            state    <= state_c;
            hdr_cnt  <= hdr_cnt_c;
            data_cnt <= data_cnt_c;
            bit_idx  <= bit_idx_c;
        end
    end

    // Shift words, cleared in idle before use
    always_ff @(posedge axi_clk) begin
        tx_word <= tx_word_c;
        rx_word <= rx_word_c;
    end

    //////////////////////////////////////////////////////////////////////
    // Frame sequencing
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_c    = state;
        hdr_cnt_c  = hdr_cnt;
        data_cnt_c = data_cnt;
        bit_idx_c  = bit_idx;
        tx_word_c  = tx_word;
        rx_word_c  = rx_word;
        cmd_rd_en  = 1'b0;
        rd_wr_en   = 1'b0;
        rd_din     = rx_word;
        pico       = 1'b0;
        cs_b       = 1'b1;
        done       = 1'b0;

        if (state != idle && data_len == '0) begin
            // Abort, deselect at once with no done and no partial push
            state_c = idle;
        end else begin
            case (state)
                idle: begin
                    hdr_cnt_c  = '0;
                    data_cnt_c = '0;
                    bit_idx_c  = '0;
                    rx_word_c  = '0;
                    // First idle bit goes out on the start cycle
                    if (data_len != '0) begin
                        cs_b    = 1'b0;
                        state_c = setup;
                    end
                end
                setup: begin
                    // Two more idle bits
                    cs_b      = 1'b0;
                    hdr_cnt_c = hdr_cnt + 1'b1;
                    if (hdr_cnt == CNT_BITS'(1)) begin
                        hdr_cnt_c = '0;
                        state_c   = send_address;
                    end
                end
                send_address: begin
                    // Address goes lowest bit first
                    cs_b      = 1'b0;
                    pico      = address[hdr_cnt[ADDR_IDX-1:0]];
                    hdr_cnt_c = hdr_cnt + 1'b1;
                    if (hdr_cnt == CNT_BITS'(ADDR_BITS - 1)) begin
                        hdr_cnt_c = '0;
                        state_c   = send_group;
                    end
                end
                send_group: begin
                    cs_b      = 1'b0;
                    pico      = opcode_group[hdr_cnt[GROUP_IDX-1:0]];
                    hdr_cnt_c = hdr_cnt + 1'b1;
                    if (hdr_cnt == CNT_BITS'(GROUP_BITS - 1)) begin
                        state_c = send_we;
                    end
                end
                send_we: begin
                    cs_b    = 1'b0;
                    pico    = wnr;
                    state_c = send_zero;
                end
                send_zero: begin
                    cs_b = 1'b0;
                    // Writes pop their first word as the header ends
                    if (wnr) begin
                        cmd_rd_en = 1'b1;
                        tx_word_c = cmd_dout;
                        state_c   = send_data;
                    end else begin
                        state_c = receive_data;
                    end
                end
                send_data: begin
                    if (data_cnt == data_len) begin
                        done    = 1'b1;
                        state_c = idle;
                    end else begin
                        cs_b       = 1'b0;
                        pico       = tx_word[bit_idx];
                        data_cnt_c = data_cnt + 1'b1;
                        bit_idx_c  = bit_idx + 1'b1;
                        // Next word only while bits remain, the tail is dropped
                        if (bit_idx == IDX_BITS'(WORD_BITS - 1) && data_cnt_c != data_len) begin
                            cmd_rd_en = 1'b1;
                            tx_word_c = cmd_dout;
                        end
                    end
                end
                receive_data: begin
                    if (data_cnt == data_len) begin
                        done    = 1'b1;
                        state_c = idle;
                        // Partial last word, upper bits already zero
                        rd_wr_en = (bit_idx != '0);
                    end else begin
                        cs_b               = 1'b0;
                        rx_word_c[bit_idx] = poci;
                        data_cnt_c         = data_cnt + 1'b1;
                        bit_idx_c          = bit_idx + 1'b1;
                        // Full word goes out with its last bit in place
                        if (bit_idx == IDX_BITS'(WORD_BITS - 1)) begin
                            rd_wr_en  = 1'b1;
                            rd_din    = rx_word_c;
                            rx_word_c = '0;
                        end
                    end
                end
                default: begin
                    state_c = idle;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // Nothing moves without a frame
    a_idle_quiet: assert property (@(posedge axi_clk) disable iff (!reset_b)
        (state == idle && data_len == '0) |-> (cs_b && !cmd_rd_en && !rd_wr_en));

    // End of frame deselects and the register block drops the length
    a_done_ends: assert property (@(posedge axi_clk) disable iff (!reset_b)
        done |-> cs_b ##1 !busy);

    // Write data must be queued before the header ends
    a_first_word: assert property (@(posedge axi_clk) disable iff (!reset_b)
        (state == send_zero && wnr && data_len != '0) |-> !cmd_empty);

    // Read frame starts with room in the read FIFO
    a_read_room: assert property (@(posedge axi_clk) disable iff (!reset_b)
        (state == idle && data_len != '0 && !wnr) |-> !rd_full);

endmodule

//--- hdl/spi_master_top.sv
/*
 * Memory-mapped SPI master
 * Register block, command and read FIFOs and the frame controller
 */
`timescale 1ns/1ps

module spi_master_top import spi_link_pkg::*; #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                 axi_clk,
    input  logic                 reset_b,
    input  logic                 reg_wr_en,
    input  logic                 reg_rd_en,
    input  reg_sel_e             reg_sel,
    input  logic [WORD_BITS-1:0] reg_wdata,
    input  logic                 poci,
    output logic [WORD_BITS-1:0] reg_rdata,
    output logic                 pico,
    output logic                 cs_b,
    output logic                 spi_clk,
    output logic                 done
);

    // Command path
    logic                  cmd_push;
    logic [WORD_BITS-1:0]  cmd_din;
    logic                  cmd_rd_en;
    logic [WORD_BITS-1:0]  cmd_dout;
    logic                  cmd_empty;

    // Read path
    logic                  rd_wr_en;
    logic [WORD_BITS-1:0]  rd_din;
    logic                  rd_full;
    logic                  read_pop;
    logic [WORD_BITS-1:0]  read_dout;
    logic                  read_empty;

    // Frame settings
    logic                  wnr;
    logic [ADDR_BITS-1:0]  address;
    logic [GROUP_BITS-1:0] opcode_group;
    logic [LEN_BITS-1:0]   data_len;
    logic                  busy;

    spi_ctrl_regs u_regs (
        .axi_clk      (axi_clk),
        .reset_b      (reset_b),
        .reg_wr_en    (reg_wr_en),
        .reg_rd_en    (reg_rd_en),
        .reg_sel      (reg_sel),
        .reg_wdata    (reg_wdata),
        .done         (done),
        .busy         (busy),
        .cmd_empty    (cmd_empty),
        .read_empty   (read_empty),
        .read_dout    (read_dout),
        .reg_rdata    (reg_rdata),
        .cmd_push     (cmd_push),
        .cmd_din      (cmd_din),
        .read_pop     (read_pop),
        .wnr          (wnr),
        .address      (address),
        .opcode_group (opcode_group),
        .data_len     (data_len)
    );

    // Software fills this one, full is left to software bookkeeping
    word_fifo #(.DEPTH(FIFO_DEPTH)) cmd_fifo (
        .axi_clk (axi_clk),
        .reset_b (reset_b),
        .wr_en   (cmd_push),
        .din     (cmd_din),
        .rd_en   (cmd_rd_en),
        .dout    (cmd_dout),
        .empty   (cmd_empty),
        .full    ()
    );

    // Sized for the longest read frame
    word_fifo #(.DEPTH(FIFO_DEPTH)) read_fifo (
        .axi_clk (axi_clk),
        .reset_b (reset_b),
        .wr_en   (rd_wr_en),
        .din     (rd_din),
        .rd_en   (read_pop),
        .dout    (read_dout),
        .empty   (read_empty),
        .full    (rd_full)
    );

    spi_frame_controller u_ctrl (
        .axi_clk      (axi_clk),
        .reset_b      (reset_b),
        .wnr          (wnr),
        .address      (address),
        .opcode_group (opcode_group),
        .data_len     (data_len),
        .cmd_empty    (cmd_empty),
        .cmd_dout     (cmd_dout),
        .rd_full      (rd_full),
        .poci         (poci),
        .cmd_rd_en    (cmd_rd_en),
        .rd_wr_en     (rd_wr_en),
        .rd_din       (rd_din),
        .pico         (pico),
        .cs_b         (cs_b),
        .spi_clk      (spi_clk),
        .done         (done),
        .busy         (busy)
    );

endmodule

//--- testbench/spi_peripheral_model.sv
/*
 * Behavioral SPI peripheral
 * Captures each frame from pico and returns read data on poci
 */
`timescale 1ns/1ps

module spi_peripheral_model import spi_link_pkg::*; (
    input  logic                  spi_clk,
    input  logic                  cs_b,
    input  logic                  pico,
    input  logic [255:0]          read_pattern,
    output logic                  poci,
    output int                    frame_cnt,
    output int                    low_cnt,
    output logic [2:0]            got_idle,
    output logic [ADDR_BITS-1:0]  got_addr,
    output logic [GROUP_BITS-1:0] got_group,
    output logic                  got_we,
    output logic                  got_zero,
    output logic [255:0]          got_data
);

    // Idle bits and header come before the data
    localparam int LEAD_BITS  = 3 + HEADER_BITS;
    localparam int MAX_DATA   = 256;
    localparam int FRAME_BITS = LEAD_BITS + MAX_DATA;

    logic [FRAME_BITS-1:0] shift_bits = '0;
    logic [FRAME_BITS-1:0] last_frame = '0;
    logic                  in_frame   = 1'b0;
    logic                  poci_drv   = 1'b0;
    int                    bit_cnt    = 0;
    int                    last_len   = 0;
    int                    frames     = 0;

    assign poci      = poci_drv;
    assign frame_cnt = frames;
    assign low_cnt   = last_len;

    // Field decode of the last closed frame, wire order
    assign got_idle  = last_frame[2:0];
    assign got_addr  = last_frame[3 +: ADDR_BITS];
    assign got_group = last_frame[3 + ADDR_BITS +: GROUP_BITS];
    assign got_we    = last_frame[3 + ADDR_BITS + GROUP_BITS];
    assign got_zero  = last_frame[LEAD_BITS - 1];
    assign got_data  = last_frame[LEAD_BITS +: MAX_DATA];

    // Mid-cycle sample, pico holds for the whole period
    always @(negedge spi_clk) begin
        if (!cs_b) begin
            if (!in_frame) begin
                shift_bits = '0;
                bit_cnt    = 0;
            end
            in_frame            = 1'b1;
            shift_bits[bit_cnt] = pico;
            bit_cnt             = bit_cnt + 1;
        end else if (in_frame) begin
            // Deselect closes the frame, aborted ones as well
            in_frame   = 1'b0;
            last_frame = shift_bits;
            last_len   = bit_cnt;
            frames     = frames + 1;
        end
    end

    // Read bit for the coming cycle, just after the rising edge
    always @(posedge spi_clk) begin
        #1;
        if (in_frame && bit_cnt >= LEAD_BITS) begin
            poci_drv = read_pattern[bit_cnt - LEAD_BITS];
        end else begin
            poci_drv = 1'b0;
        end
    end

endmodule

//--- testbench/tb_spi_master_top.sv
/*
 * Testbench for the memory-mapped SPI master
 * Write, read and aborted frames checked against a peripheral model
 */
`timescale 1ns/1ps

module tb_spi_master_top import spi_link_pkg::*; ();

    localparam int LEAD_BITS    = 3 + HEADER_BITS;
    localparam int MAX_DATA     = 256;
    // Longest frame is 271 cycles plus up to 8 pushes, 8 pops and setup
    localparam int FRAME_BUDGET = 500;
    localparam int MAX_FRAMES   = 12;
    localparam int TIMEOUT_CYCLES = MAX_FRAMES * FRAME_BUDGET;
    // Abort lands 5 data bits in before any full word
    localparam int ABORT_CYCLES = LEAD_BITS + 5;

    logic                  axi_clk = 1'b0;
    logic                  reset_b;
    logic                  reg_wr_en;
    logic                  reg_rd_en;
    reg_sel_e              reg_sel;
    logic [WORD_BITS-1:0]  reg_wdata;
    logic [WORD_BITS-1:0]  reg_rdata;
    logic                  poci;
    logic                  pico;
    logic                  cs_b;
    logic                  spi_clk;
    logic                  done;
    logic [MAX_DATA-1:0]   read_pattern;

    // Peripheral capture
    int                    frame_cnt;
    int                    low_cnt;
    logic [2:0]            got_idle;
    logic [ADDR_BITS-1:0]  got_addr;
    logic [GROUP_BITS-1:0] got_group;
    logic                  got_we;
    logic                  got_zero;
    logic [MAX_DATA-1:0]   got_data;

    int done_count  = 0;
    int cycle_count = 0;
    int frames_run  = 0;

    spi_master_top #(.FIFO_DEPTH(8)) uut (
        .axi_clk   (axi_clk),
        .reset_b   (reset_b),
        .reg_wr_en (reg_wr_en),
        .reg_rd_en (reg_rd_en),
        .reg_sel   (reg_sel),
        .reg_wdata (reg_wdata),
        .poci      (poci),
        .reg_rdata (reg_rdata),
        .pico      (pico),
        .cs_b      (cs_b),
        .spi_clk   (spi_clk),
        .done      (done)
    );

    spi_peripheral_model u_peripheral (
        .spi_clk      (spi_clk),
        .cs_b         (cs_b),
        .pico         (pico),
        .read_pattern (read_pattern),
        .poci         (poci),
        .frame_cnt    (frame_cnt),
        .low_cnt      (low_cnt),
        .got_idle     (got_idle),
        .got_addr     (got_addr),
        .got_group    (got_group),
        .got_we       (got_we),
        .got_zero     (got_zero),
        .got_data     (got_data)
    );

    always #4 axi_clk = ~axi_clk;

    // Done is combinational so it is counted mid-cycle
    always @(negedge axi_clk) begin
        if (reset_b && done) begin
            done_count <= done_count + 1;
        end
    end

    // Link clock follows the bus clock with no divider
    always @(axi_clk) begin
        #1;
        check_state_flag("spi_clk", spi_clk, axi_clk);
    end

    always @(posedge axi_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTS FAILED");
            $fatal(1, "Simulation timed out");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    // Pico data bits from command words lowest bit first and cut at the length
    function automatic logic [MAX_DATA-1:0] expected_stream(
        input logic [WORD_BITS-1:0] words [8], input int len);
        logic [MAX_DATA-1:0] bits;
        bits = '0;
        for (int i = 0; i < len; i++) begin
            bits[i] = words[i / WORD_BITS][i % WORD_BITS];
        end
        return bits;
    endfunction

    // Read word k with poci bits lowest first and zero past the length
    function automatic logic [WORD_BITS-1:0] expected_read_word(
        input logic [MAX_DATA-1:0] pattern, input int len, input int k);
        logic [WORD_BITS-1:0] word;
        word = '0;
        for (int i = 0; i < WORD_BITS; i++) begin
            if (k * WORD_BITS + i < len) begin
                word[i] = pattern[k * WORD_BITS + i];
            end
        end
        return word;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_word(input string what, input logic [WORD_BITS-1:0] got,
        input logic [WORD_BITS-1:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "Word mismatch");
        end
    endtask

    task automatic check_field(input string what, input logic [7:0] got,
        input logic [7:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "Field mismatch");
        end
    endtask

    task automatic check_state_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "Flag mismatch");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Register port and frame sequences
    //////////////////////////////////////////////////////////////////////

    // All accesses start and end 1 ns after a rising edge
    task automatic reg_write(input reg_sel_e sel, input logic [WORD_BITS-1:0] data);
        reg_sel   = sel;
        reg_wdata = data;
        reg_wr_en = 1'b1;
        @(posedge axi_clk);
        #1;
        reg_wr_en = 1'b0;
    endtask

    task automatic reg_read(input reg_sel_e sel, output logic [WORD_BITS-1:0] data);
        reg_sel   = sel;
        reg_rd_en = 1'b1;
        @(posedge axi_clk);
        #1;
        reg_rd_en = 1'b0;
        data      = reg_rdata;
    endtask

    task automatic wait_for_done(input int done_before);
        while (done_count == done_before) begin
            @(posedge axi_clk);
            #1;
        end
    endtask

    task automatic wait_for_close(input int frames_before);
        while (frame_cnt == frames_before) begin
            @(posedge axi_clk);
            #1;
        end
    endtask

    task automatic check_header(input logic [ADDR_BITS-1:0] addr,
        input logic [GROUP_BITS-1:0] group, input logic we, input int len);
        check_field("idle bits", 8'(got_idle), 8'h00);
        check_field("address", got_addr, addr);
        check_field("opcode group", 8'(got_group), 8'(group));
        check_state_flag("write enable", got_we, we);
        check_state_flag("zero bit", got_zero, 1'b0);
        check_word("cs_b low cycles", 32'(low_cnt), 32'(LEAD_BITS + len));
    endtask

    // Idle status, cleared length and the number of done pulses
    task automatic check_frame_end(input int done_before, input int exp_done);
        logic [WORD_BITS-1:0] value;
        reg_read(sel_status, value);
        check_state_flag("busy after frame", value[0], 1'b0);
        check_state_flag("command FIFO empty", value[1], 1'b1);
        check_state_flag("read FIFO empty", value[2], 1'b1);
        reg_read(sel_length, value);
        check_word("length after frame", value, '0);
        check_word("done pulses", 32'(done_count - done_before), 32'(exp_done));
    endtask

    task automatic send_write_frame(input int len);
        logic [WORD_BITS-1:0]  words [8];
        logic [MAX_DATA-1:0]   exp_bits;
        logic [ADDR_BITS-1:0]  addr;
        logic [GROUP_BITS-1:0] group;
        int                    done_before;
        addr  = ADDR_BITS'($urandom);
        group = GROUP_BITS'($urandom);
        for (int k = 0; k < 8; k++) begin
            words[k] = $urandom;
        end
        // Queue only the words this frame pops
        for (int k = 0; k < (len + WORD_BITS - 1) / WORD_BITS; k++) begin
            reg_write(sel_cmd_data, words[k]);
        end
        reg_write(sel_ctrl, WORD_BITS'({group, 1'b1}));
        reg_write(sel_address, WORD_BITS'(addr));
        done_before = done_count;
        reg_write(sel_length, WORD_BITS'(len));
        wait_for_done(done_before);
        frames_run++;
        check_header(addr, group, 1'b1, len);
        exp_bits = expected_stream(words, len);
        for (int k = 0; k < 8; k++) begin
            check_word($sformatf("write data bits %0d", k * WORD_BITS),
                got_data[k * WORD_BITS +: WORD_BITS], exp_bits[k * WORD_BITS +: WORD_BITS]);
        end
        check_frame_end(done_before, 1);
    endtask

    task automatic send_read_frame(input int len);
        logic [MAX_DATA-1:0]   pattern;
        logic [WORD_BITS-1:0]  value;
        logic [ADDR_BITS-1:0]  addr;
        logic [GROUP_BITS-1:0] group;
        int                    done_before;
        addr  = ADDR_BITS'($urandom);
        group = GROUP_BITS'($urandom);
        for (int k = 0; k < 8; k++) begin
            pattern[k * WORD_BITS +: WORD_BITS] = $urandom;
        end
        read_pattern = pattern;
        reg_write(sel_ctrl, WORD_BITS'({group, 1'b0}));
        reg_write(sel_address, WORD_BITS'(addr));
        done_before = done_count;
        reg_write(sel_length, WORD_BITS'(len));
        wait_for_done(done_before);
        frames_run++;
        check_header(addr, group, 1'b0, len);
        // Whole words rounded up with the empty flag showing there are no extras
        for (int k = 0; k < (len + WORD_BITS - 1) / WORD_BITS; k++) begin
            reg_read(sel_read_data, value);
            check_word($sformatf("read word %0d", k), value, expected_read_word(pattern, len, k));
        end
        check_frame_end(done_before, 1);
    endtask

    task automatic abort_read_frame();
        int frames_before;
        int done_before;
        read_pattern = {8{32'hA5C3_0F96}};
        reg_write(sel_ctrl, WORD_BITS'(0));
        frames_before = frame_cnt;
        done_before   = done_count;
        reg_write(sel_length, WORD_BITS'(100));
        repeat (ABORT_CYCLES - 1) @(posedge axi_clk);
        #1;
        reg_write(sel_length, '0);
        check_state_flag("cs_b after abort", cs_b, 1'b1);
        wait_for_close(frames_before);
        check_word("cs_b low cycles in aborted frame", 32'(low_cnt), 32'(ABORT_CYCLES));
        // Room for a late done pulse to show up
        repeat (4) @(posedge axi_clk);
        #1;
        check_frame_end(done_before, 0);
    endtask

    initial begin
        void'($urandom(13));
        reset_b      = 1'b0;
        reg_wr_en    = 1'b0;
        reg_rd_en    = 1'b0;
        reg_sel      = sel_ctrl;
        reg_wdata    = '0;
        read_pattern = '0;
        repeat (2) @(posedge axi_clk);
        #1;
        reset_b = 1'b1;
        @(posedge axi_clk);
        #1;

        // Random header and length
        send_write_frame($urandom_range(255, 1));
        // Lengths around word boundaries up to the longest frame
        send_write_frame(1);
        send_write_frame(32);
        send_write_frame(33);
        send_write_frame(255);
        // Partial last word, whole words, longest read
        send_read_frame($urandom_range(255, 1));
        send_read_frame(64);
        send_read_frame(255);
        // Abort then a clean frame
        abort_read_frame();
        send_write_frame($urandom_range(255, 1));

        if (done_count == frames_run) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("Saw %0d done pulses for %0d completed frames", done_count, frames_run);
            $display("TESTS FAILED");
            $fatal(1, "Done pulse count mismatch");
        end
    end

endmodule

//--- list.f
hdl/spi_link_pkg.sv
hdl/word_fifo.sv
hdl/spi_ctrl_regs.sv
hdl/spi_frame_controller.sv
hdl/spi_master_top.sv
testbench/spi_peripheral_model.sv
testbench/tb_spi_master_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the SPI master testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f list.f \
    --top-module tb_spi_master_top -o sim_tb

out=$(./obj_dir/sim_tb 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "TESTS PASSED"; then
    exit 0
else
    exit 1
fi
